// ==== source/ntt_field_pkg.sv ====
`default_nettype none

package ntt_field_pkg;

        // prime field q = 2^16 + 1.
        localparam int elem_w = 17;
        localparam logic [elem_w-1:0] field_modulus = 17'd65537;

        localparam int twiddle_addr_w = 7;

        // reduced element, 0 to 65536.
        typedef logic [elem_w-1:0] field_elem_t;

        // full product before reduction.
        typedef logic [2*elem_w-1:0] prod_t;

        typedef logic [twiddle_addr_w-1:0] twiddle_addr_t;

endpackage

`default_nettype wire

// ==== source/ntt_stream_pkg.sv ====
`default_nettype none

package ntt_stream_pkg;

        import ntt_field_pkg::*;

        typedef struct packed {
                field_elem_t   a;
                field_elem_t   b;
                twiddle_addr_t addr;
        } bfly_job_t;

        typedef struct packed {
                field_elem_t sum;  // (a + b) mod q.
                field_elem_t prod; // ((a - b) * w) mod q.
        } bfly_res_t;

        // multiplier register stages that follow the add/sub stage.
        localparam int arith_depth = 2;
        localparam int max_in_flight = 4;

endpackage

`default_nettype wire

// ==== source/bfly_if.sv ====
`default_nettype none

interface bfly_if #(
        parameter type payload_t = logic
);

        logic     valid;
        logic     ready;
        payload_t payload;

        // producer side.
        modport source (
                output valid,
                output payload,
                input  ready
        );

        // consumer side.
        modport sink (
                input  valid,
                input  payload,
                output ready
        );

endinterface

`default_nettype wire

// ==== source/psi_inv_table.sv ====
`default_nettype none

module psi_inv_table
        import ntt_field_pkg::*;
(
        input  twiddle_addr_t addr,
        output field_elem_t   value
);

        // even and odd neighbours map to the same power.
        always_comb begin
                case (addr)
                7'd0,   7'd1:   value = 17'd1;
                7'd2,   7'd3:   value = 17'd1;
                7'd4,   7'd5:   value = 17'd65536;
                7'd6,   7'd7:   value = 17'd16384;
                7'd8,   7'd9:   value = 17'd65281;
                7'd10,  7'd11:  value = 17'd65473;
                7'd12,  7'd13:  value = 17'd65521;
                7'd14,  7'd15:  value = 17'd65533;
                7'd16,  7'd17:  value = 17'd61441;
                7'd18,  7'd19:  value = 17'd64513;
                7'd20,  7'd21:  value = 17'd65281;
                7'd22,  7'd23:  value = 17'd65473;
                7'd24,  7'd25:  value = 17'd65521;
                7'd26,  7'd27:  value = 17'd65533;
                7'd28,  7'd29:  value = 17'd65536;
                7'd30,  7'd31:  value = 17'd16384;
                7'd32,  7'd33:  value = 17'd49153;
                7'd34,  7'd35:  value = 17'd61441;
                7'd36,  7'd37:  value = 17'd64513;
                7'd38,  7'd39:  value = 17'd65281;
                7'd40,  7'd41:  value = 17'd65473;
                7'd42,  7'd43:  value = 17'd65521;
                7'd44,  7'd45:  value = 17'd65533;
                7'd46,  7'd47:  value = 17'd65536;
                7'd48,  7'd49:  value = 17'd16384;
                7'd50,  7'd51:  value = 17'd4096;
                7'd52,  7'd53:  value = 17'd1024;
                7'd54,  7'd55:  value = 17'd256;
                7'd56,  7'd57:  value = 17'd64;
                7'd58,  7'd59:  value = 17'd16;
                7'd60,  7'd61:  value = 17'd4;
                7'd62,  7'd63:  value = 17'd1;
                7'd64,  7'd65:  value = 17'd32769;
                7'd66,  7'd67:  value = 17'd57345;
                7'd68,  7'd69:  value = 17'd63489;
                7'd70,  7'd71:  value = 17'd65025;
                7'd72,  7'd73:  value = 17'd65409;
                7'd74,  7'd75:  value = 17'd65505;
                7'd76,  7'd77:  value = 17'd65529;
                7'd78,  7'd79:  value = 17'd65535;
                7'd80,  7'd81:  value = 17'd32768;
                7'd82,  7'd83:  value = 17'd8192;
                7'd84,  7'd85:  value = 17'd2048;
                7'd86,  7'd87:  value = 17'd512;
                7'd88,  7'd89:  value = 17'd128;
                7'd90,  7'd91:  value = 17'd32;
                7'd92,  7'd93:  value = 17'd8;
                7'd94,  7'd95:  value = 17'd2;
                7'd96,  7'd97:  value = 17'd32769;
                7'd98,  7'd99:  value = 17'd57345;
                7'd100, 7'd101: value = 17'd63489;
                7'd102, 7'd103: value = 17'd65025;
                7'd104, 7'd105: value = 17'd65409;
                7'd106, 7'd107: value = 17'd65505;
                7'd108, 7'd109: value = 17'd65529;
                7'd110, 7'd111: value = 17'd65535;
                7'd112, 7'd113: value = 17'd32768;
                7'd114, 7'd115: value = 17'd8192;
                7'd116, 7'd117: value = 17'd2048;
                7'd118, 7'd119: value = 17'd512;
                7'd120, 7'd121: value = 17'd128;
                7'd122, 7'd123: value = 17'd32;
                7'd124, 7'd125: value = 17'd8;
                7'd126, 7'd127: value = 17'd2;
                default:        value = '0;
                endcase
        end

endmodule

`default_nettype wire

// ==== source/stream_reg.sv ====
`default_nettype none

module stream_reg #(
        parameter type payload_t = logic
) (
        input wire logic clk,
        input wire logic reset,
        bfly_if.sink     up,
        bfly_if.source   down
);

        logic     main_valid;
        logic     skid_valid;
        logic     skid_valid_nx;
        logic     ready_q;
        logic     up_fire;
        logic     main_free;
        payload_t main_data;
        payload_t skid_data;

        assign up.ready     = ready_q;     // registered, no path from down.ready.
        assign down.valid   = main_valid;
        assign down.payload = main_data;

        always_comb begin
                up_fire   = up.valid && ready_q;
                main_free = !main_valid || down.ready;
                skid_valid_nx = skid_valid;
                if (main_free) begin
                        skid_valid_nx = 1'b0;  // skid drains into main.
                end else if (up_fire) begin
                        skid_valid_nx = 1'b1;  // main stalled, park the beat.
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        main_valid <= 1'b0;
                        skid_valid <= 1'b0;
                        ready_q    <= 1'b0;
                end else begin
                        skid_valid <= skid_valid_nx;
                        ready_q    <= !skid_valid_nx;
                        if (main_free) begin
                                main_valid <= skid_valid || up_fire;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (main_free) begin
                        main_data <= skid_valid ? skid_data : up.payload;
                end
                if (!main_free && up_fire) begin
                        skid_data <= up.payload;
                end
        end

endmodule

`default_nettype wire

// ==== source/mod_arith.sv ====
`default_nettype none

module mod_arith
        import ntt_field_pkg::*;
        import ntt_stream_pkg::*;
(
        input  wire logic  clk,
        input  wire logic  reset,
        input  wire logic  advance,
        input  bfly_job_t  job,
        output field_elem_t sum,
        output field_elem_t diff,
        output field_elem_t w
);

        logic [elem_w:0] sum_raw;
        logic [elem_w:0] sum_red;
        logic [elem_w:0] diff_raw;
        logic [elem_w:0] diff_red;
        field_elem_t     w_lookup;

        psi_inv_table psi_inv_table_i (
                .addr  (job.addr),
                .value (w_lookup)
        );

        always_comb begin
                sum_raw  = {1'b0, job.a} + {1'b0, job.b};
                sum_red  = (sum_raw >= {1'b0, field_modulus}) ?
                           sum_raw - {1'b0, field_modulus} : sum_raw;
                diff_raw = {1'b0, job.a} - {1'b0, job.b};   // wraps when a < b.
                diff_red = (job.a >= job.b) ? diff_raw : diff_raw + {1'b0, field_modulus};
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        sum  <= '0;
                        diff <= '0;
                        w    <= '0;
                end else if (advance) begin
                        sum  <= sum_red[elem_w-1:0];
                        diff <= diff_red[elem_w-1:0];
                        w    <= w_lookup;
                end
        end

endmodule

`default_nettype wire

// ==== source/mod_mult_pipe.sv ====
`default_nettype none

module mod_mult_pipe
        import ntt_field_pkg::*;
(
        input  wire logic   clk,
        input  wire logic   reset,
        input  wire logic   advance,
        input  field_elem_t x,
        input  field_elem_t y,
        input  field_elem_t carry_in,
        output field_elem_t prod,
        output field_elem_t carry_out
);

        prod_t           prod_raw;
        field_elem_t     carry_mid;
        logic [elem_w:0] lo_part;
        logic [elem_w:0] hi_part;
        logic [elem_w:0] reduced;

        // stage 1, full product.
        always_ff @(posedge clk) begin
                if (reset) begin
                        prod_raw  <= '0;
                        carry_mid <= '0;
                end else if (advance) begin
                        prod_raw  <= prod_t'(x) * prod_t'(y);
                        carry_mid <= carry_in;
                end
        end

        // 2^16 = -1 mod q, so p = hi * 2^16 + lo reduces to lo - hi.
        always_comb begin
                lo_part = {2'b00, prod_raw[15:0]};
                hi_part = prod_raw[33:16];  // at most 2^16 for reduced inputs.
                if (lo_part >= hi_part) begin
                        reduced = lo_part - hi_part;
                end else begin
                        reduced = lo_part + {1'b0, field_modulus} - hi_part;
                end
        end

        // stage 2, reduced result.
        always_ff @(posedge clk) begin
                if (reset) begin
                        prod      <= '0;
                        carry_out <= '0;
                end else if (advance) begin
                        prod      <= reduced[elem_w-1:0];
                        carry_out <= carry_mid;
                end
        end

endmodule

`default_nettype wire

// ==== source/bfly_ctrl.sv ====
`default_nettype none

module bfly_ctrl
        import ntt_stream_pkg::*;
(
        input  wire logic        clk,
        input  wire logic        reset,
        bfly_if.sink             job,
        output logic             res_valid,
        input  wire logic        res_ready,
        output logic             advance,
        output logic [2:0]       occupancy
);

        // one bit for the add/sub stage, then one per multiplier stage.
        logic [arith_depth:0] stage_valid;
        logic                 job_fire;
        logic                 res_fire;

        assign res_valid = stage_valid[arith_depth];
        assign advance   = !stage_valid[arith_depth] || res_ready;
        assign job.ready = advance;

        assign job_fire = job.valid && advance;
        assign res_fire = res_valid && res_ready;

        always_ff @(posedge clk) begin
                if (reset) begin
                        stage_valid <= '0;
                end else if (advance) begin
                        stage_valid <= {stage_valid[arith_depth-1:0], job.valid};
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        occupancy <= '0;
                end else begin
                        case ({job_fire, res_fire})
                        2'b10:   occupancy <= occupancy + 3'd1;
                        2'b01:   occupancy <= occupancy - 3'd1;
                        default: occupancy <= occupancy;  // none or both.
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== source/ntt_bfly_top.sv ====
`default_nettype none

module ntt_bfly_top
        import ntt_field_pkg::*;
        import ntt_stream_pkg::*;
(
        input  wire logic    clk,
        input  wire logic    reset,
        input  wire logic    in_valid,
        output logic         in_ready,
        input  field_elem_t  in_a,
        input  field_elem_t  in_b,
        input  twiddle_addr_t in_addr,
        output logic         out_valid,
        input  wire logic    out_ready,
        output field_elem_t  out_sum,
        output field_elem_t  out_prod
);

        bfly_if #(.payload_t(bfly_job_t)) in_bus ();
        bfly_if #(.payload_t(bfly_job_t)) job_bus ();
        bfly_if #(.payload_t(bfly_res_t)) res_bus ();
        bfly_if #(.payload_t(bfly_res_t)) out_bus ();

        logic        advance;
        field_elem_t arith_sum;
        field_elem_t arith_diff;
        field_elem_t arith_w;
        field_elem_t res_sum;
        field_elem_t res_prod;

        assign in_bus.valid   = in_valid;
        assign in_bus.payload = '{a: in_a, b: in_b, addr: in_addr};
        assign in_ready       = in_bus.ready;

        assign res_bus.payload = '{sum: res_sum, prod: res_prod};

        assign out_valid     = out_bus.valid;
        assign out_sum       = out_bus.payload.sum;
        assign out_prod      = out_bus.payload.prod;
        assign out_bus.ready = out_ready;

        stream_reg #(.payload_t(bfly_job_t)) in_reg_i (
                .clk   (clk),
                .reset (reset),
                .up    (in_bus.sink),
                .down  (job_bus.source)
        );

        bfly_ctrl bfly_ctrl_i (
                .clk       (clk),
                .reset     (reset),
                .job       (job_bus.sink),
                .res_valid (res_bus.valid),
                .res_ready (res_bus.ready),
                .advance   (advance),
                .occupancy ()              // watched by the bound checks.
        );

        mod_arith mod_arith_i (
                .clk     (clk),
                .reset   (reset),
                .advance (advance),
                .job     (job_bus.payload),
                .sum     (arith_sum),
                .diff    (arith_diff),
                .w       (arith_w)
        );

        mod_mult_pipe mod_mult_pipe_i (
                .clk       (clk),
                .reset     (reset),
                .advance   (advance),
                .x         (arith_diff),
                .y         (arith_w),
                .carry_in  (arith_sum),
                .prod      (res_prod),
                .carry_out (res_sum)
        );

        stream_reg #(.payload_t(bfly_res_t)) out_reg_i (
                .clk   (clk),
                .reset (reset),
                .up    (res_bus.sink),
                .down  (out_bus.source)
        );

endmodule

`default_nettype wire

// ==== dv/ntt_bfly_props.sv ====
`default_nettype none

module ntt_bfly_props
        import ntt_stream_pkg::*;
(
        input wire logic       clk,
        input wire logic       reset,
        input wire logic       job_valid,
        input wire logic       job_ready,
        input wire bfly_job_t  job_payload,
        input wire logic       res_valid,
        input wire logic [2:0] occupancy
);

        // a pending job keeps valid and payload until it is taken.
        job_hold: assert property (@(posedge clk) disable iff (reset)
                job_valid && !job_ready |=> job_valid && $stable(job_payload))
                else $error("job bus changed a pending job");

        occupancy_cap: assert property (@(posedge clk) disable iff (reset)
                occupancy <= 3'(max_in_flight))
                else $error("too many jobs between the skid registers");

        reset_clear: assert property (@(posedge clk)
                reset |=> !res_valid && occupancy == 3'd0)
                else $error("pipeline state not cleared by reset");

endmodule

bind bfly_ctrl ntt_bfly_props ntt_bfly_props_i (
        .clk         (clk),
        .reset       (reset),
        .job_valid   (job.valid),
        .job_ready   (job.ready),
        .job_payload (job.payload),
        .res_valid   (res_valid),
        .occupancy   (occupancy)
);

`default_nettype wire

// ==== dv/ntt_bfly_tb.sv ====
`default_nettype none

module ntt_bfly_tb;

        localparam int wait_limit = 1000;
        localparam int latency = 4;
        localparam logic [31:0] seed = 32'h9b00;
        localparam int edge_vals [4] = '{0, 1, 65535, 65536};

        // inverse twiddles, one entry for each even/odd address pair.
        localparam int psi_ref [64] = '{
                1, 1, 65536, 16384, 65281, 65473, 65521, 65533,
                61441, 64513, 65281, 65473, 65521, 65533, 65536, 16384,
                49153, 61441, 64513, 65281, 65473, 65521, 65533, 65536,
                16384, 4096, 1024, 256, 64, 16, 4, 1,
                32769, 57345, 63489, 65025, 65409, 65505, 65529, 65535,
                32768, 8192, 2048, 512, 128, 32, 8, 2,
                32769, 57345, 63489, 65025, 65409, 65505, 65529, 65535,
                32768, 8192, 2048, 512, 128, 32, 8, 2
        };

        logic        clk = 1'b0;
        logic        reset;
        logic        in_valid;
        logic        in_ready;
        logic [16:0] in_a;
        logic [16:0] in_b;
        logic [6:0]  in_addr;
        logic        out_valid;
        logic        out_ready = 1'b1;
        logic [16:0] out_sum;
        logic [16:0] out_prod;

        logic [31:0] stim_rng = seed;
        logic [31:0] ready_rng = ~seed;
        logic        throttle = 1'b0;
        logic        check_latency = 1'b0;
        logic [33:0] exp_q [$];   // {sum, prod} per accepted job.
        int          in_cycle_q [$];
        int          cycle = 0;
        int          jobs_sent = 0;
        int          out_count = 0;
        int          check_count = 0;
        int          value_errors = 0;
        int          other_errors = 0;

        ntt_bfly_top ntt_bfly_top_i (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_a      (in_a),
                .in_b      (in_b),
                .in_addr   (in_addr),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_sum   (out_sum),
                .out_prod  (out_prod)
        );

        always #10 clk = ~clk;

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                return s ^ (s << 5);
        endfunction

        function automatic int rand_elem();
                stim_rng = xorshift(stim_rng);
                return int'(stim_rng % 32'd65537);
        endfunction

        // gentleman-sande inverse butterfly, result packed as {sum, prod}.
        function automatic logic [33:0] bfly_ref(input int a, input int b, input int addr);
                longint q;
                longint s;
                longint d;
                q = 65537;
                s = (a + b) % q;
                d = (a - b + q) % q;
                return {17'(s), 17'((d * psi_ref[addr / 2]) % q)};
        endfunction

        task automatic check_value(input string what, input int got, input int expected);
                check_count++;
                if (got != expected) begin
                        value_errors++;
                        $display("Error at time %0t: %s is %0d, expected %0d",
                                 $time, what, got, expected);
                end
        endtask

        task automatic send_job(input int a, input int b, input int addr);
                int waited;
                waited = 0;
                in_valid = 1'b1;
                in_a     = 17'(a);
                in_b     = 17'(b);
                in_addr  = 7'(addr);
                while (!in_ready && waited < wait_limit) begin
                        @(negedge clk);
                        waited++;
                end
                if (in_ready) begin
                        @(negedge clk);  // taken on the rising edge just passed.
                        jobs_sent++;
                end else begin
                        other_errors++;
                        $display("in_ready stayed low for %0d cycles, job dropped", wait_limit);
                end
                in_valid = 1'b0;
        endtask

        task automatic wait_drain();
                int waited;
                waited = 0;
                while (exp_q.size() != 0 && waited < wait_limit) begin
                        @(negedge clk);
                        waited++;
                end
                if (exp_q.size() != 0) begin
                        other_errors++;
                        $display("%0d results never came out", exp_q.size());
                end
        endtask

        task automatic finish_run();
                $display("checks: %0d, value errors: %0d, other errors: %0d",
                         check_count, value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        endtask

        always @(negedge clk) begin
                ready_rng = xorshift(ready_rng);
                out_ready = throttle ? ready_rng[0] : 1'b1;
        end

        // scoreboard, sampled before the DUT registers update.
        always @(posedge clk) begin
                logic [33:0] expected;
                int          in_at;
                if (!reset && in_valid && in_ready) begin
                        exp_q.push_back(bfly_ref(int'(in_a), int'(in_b), int'(in_addr)));
                        in_cycle_q.push_back(cycle);
                end
                if (out_valid && out_ready) begin
                        out_count++;
                        if (exp_q.size() == 0) begin
                                other_errors++;
                                $display("output transfer at time %0t with no job pending", $time);
                        end else begin
                                expected = exp_q.pop_front();
                                in_at = in_cycle_q.pop_front();
                                check_value("out_sum", int'(out_sum), int'(expected[33:17]));
                                check_value("out_prod", int'(out_prod), int'(expected[16:0]));
                                check_value("out_prod range", int'(out_prod <= 17'd65536), 1);
                                if (check_latency) begin
                                        // out_valid rose one edge before this transfer.
                                        check_value("latency", cycle - in_at - 1, latency);
                                end
                        end
                end
                cycle = cycle + 1;
        end

        initial begin
                reset    = 1'b1;
                in_valid = 1'b0;
                in_a     = '0;
                in_b     = '0;
                in_addr  = '0;
                for (int i = 0; i < 4; i++) begin
                        @(negedge clk);
                        check_value("out_valid in reset", int'(out_valid), 0);
                end
                reset = 1'b0;
                @(negedge clk);
                check_value("out_valid after reset", int'(out_valid), 0);
                check_value("in_ready after reset", int'(in_ready), 1);

                for (int addr = 0; addr < 128; addr++) begin
                        send_job(1, 0, addr);
                end
                wait_drain();

                check_latency = 1'b1;
                for (int i = 0; i < 200; i++) begin
                        send_job(rand_elem(), rand_elem(), rand_elem() % 128);
                end
                wait_drain();
                check_latency = 1'b0;

                throttle = 1'b1;
                for (int i = 0; i < 300; i++) begin
                        send_job(rand_elem(), rand_elem(), rand_elem() % 128);
                end
                wait_drain();
                throttle = 1'b0;

                foreach (edge_vals[i]) begin
                        foreach (edge_vals[j]) begin
                                send_job(edge_vals[i], edge_vals[j], rand_elem() % 128);
                        end
                end
                wait_drain();
                repeat (10) @(negedge clk);  // any extra result shows up here.
                check_value("result count", out_count, jobs_sent);
                finish_run();
        end

endmodule

`default_nettype wire

// ==== build.f ====
source/ntt_field_pkg.sv
source/ntt_stream_pkg.sv
source/bfly_if.sv
source/psi_inv_table.sv
source/stream_reg.sv
source/mod_arith.sv
source/mod_mult_pipe.sv
source/bfly_ctrl.sv
source/ntt_bfly_top.sv
dv/ntt_bfly_props.sv
dv/ntt_bfly_tb.sv

// ==== Makefile ====
# Verilator build and run for the butterfly engine testbench.
VERILATOR ?= verilator
TOP       ?= ntt_bfly_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code.
run: compile
	./$(BINARY) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
